// File: design/types.sv
/* Shared datapath typedefs for the command front end */
`default_nettype none

package types;

    // One byte as delivered by the UART receiver
    typedef logic [7:0] byte_t;

    // First byte of every command
    typedef logic [7:0] opcode_t;

    // Watchdog kick signature, four bytes received MSB first
    typedef logic [31:0] watchdog_pattern_t;

    // Index into the control register bank
    typedef logic [1:0] reg_addr_t;

endpackage

`default_nettype wire

// File: design/params.sv
/* Default values for the signature, watchdog period, opcodes, baud divisor
   and register count */
`default_nettype none

package params;

    // Kick pattern expected by the watchdog handler
    parameter types::watchdog_pattern_t WATCHDOG_SIGNATURE_PATTERN = 32'hA5C3_5A3C;
    parameter int WATCHDOG_SIGBYTES = 4;  // Bytes in the pattern above

    // Clocks between kicks before a system reset is issued
    parameter int WATCHDOG_CONTROL_TICKS = 10000;

    parameter types::opcode_t OPCODE_WATCHDOG  = 8'h01;
    parameter types::opcode_t OPCODE_REG_WRITE = 8'h02;

    // 100 MHz clock at 115200 baud
    parameter int CLKS_PER_BIT = 868;

    parameter int NUM_CTRL_REGS = 4;

endpackage

`default_nettype wire

// File: design/uart_byte_rx.sv
/* UART receiver, 8N1, mid-bit sampling with start-bit recheck */
`timescale 1ns/10ps
`default_nettype none

module uart_byte_rx #(
    parameter int CLKS_PER_BIT = params::CLKS_PER_BIT
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         rx,
    output types::byte_t rx_data,
    output logic         rx_valid
);
    import types::*;

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } rx_state_t;

    rx_state_t        state;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    byte_t            shift;
    logic             rx_meta;
    logic             rx_sync;

    // Two-flop synchronizer, the line idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    bit_cnt <= '0;
                    if (!rx_sync) state <= S_START;  // Falling edge of start bit
                end
                S_START: begin
                    if (bit_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        // Line went back high before mid-bit, so it was a glitch
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? S_IDLE : S_DATA;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (bit_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= S_STOP;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_STOP: begin
                    if (bit_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        rx_valid <= rx_sync;  // Bad stop bit drops the byte
                        state    <= S_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == S_DATA && bit_cnt == CNT_W'(CLKS_PER_BIT - 1)) shift <= {rx_sync, shift[7:1]};
        if (state == S_STOP && bit_cnt == CNT_W'(CLKS_PER_BIT - 1)) rx_data <= shift;
    end

    a_valid_single: assert property (@(posedge clk) disable iff (reset)
        rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

// File: design/control_cmd_dispatch.sv
/* Opcode decoder that hands the following command bytes to one handler
   until that handler reports done */
`timescale 1ns/10ps
`default_nettype none

module control_cmd_dispatch #(
    parameter types::opcode_t OPCODE_WATCHDOG  = params::OPCODE_WATCHDOG,
    parameter types::opcode_t OPCODE_REG_WRITE = params::OPCODE_REG_WRITE
) (
    input  logic         clk,
    input  logic         reset,
    input  types::byte_t rx_data,
    input  logic         rx_valid,
    input  logic         wd_done,
    input  logic         reg_done,
    output types::byte_t cmd_data,
    output logic         wd_enable,
    output logic         reg_enable,
    output logic         cmd_error
);
    import types::*;

    typedef enum logic [1:0] {
        S_OPCODE,
        S_WATCHDOG,
        S_REG_WRITE
    } dispatch_state_t;

    dispatch_state_t state;
    opcode_t         opcode;

    assign opcode   = opcode_t'(rx_data);
    assign cmd_data = rx_data;

    // Handlers see the operand byte in the same cycle as the strobe
    assign wd_enable  = (state == S_WATCHDOG) && rx_valid;
    assign reg_enable = (state == S_REG_WRITE) && rx_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_OPCODE;
            cmd_error <= 1'b0;
        end else begin
            cmd_error <= 1'b0;
            case (state)
                S_OPCODE: begin
                    if (rx_valid) begin
                        if (opcode == OPCODE_WATCHDOG) begin
                            state <= S_WATCHDOG;
                        end else if (opcode == OPCODE_REG_WRITE) begin
                            state <= S_REG_WRITE;
                        end else begin
                            cmd_error <= 1'b1;  // Unknown opcode, byte is dropped
                        end
                    end
                end
                S_WATCHDOG: begin
                    if (wd_done) state <= S_OPCODE;
                end
                S_REG_WRITE: begin
                    if (reg_done) state <= S_OPCODE;
                end
                default: state <= S_OPCODE;
            endcase
        end
    end

    a_one_handler: assert property (@(posedge clk) disable iff (reset)
        !(wd_enable && reg_enable));

endmodule

`default_nettype wire

// File: design/control_cmd_watchdog.sv
/* Watchdog handler that reloads its tick counter on a matching signature
   and pulses sys_reset when the counter runs out */
`timescale 1ns/10ps
`default_nettype none

module control_cmd_watchdog #(
    parameter types::watchdog_pattern_t WATCHDOG_SIGNATURE_PATTERN =
        params::WATCHDOG_SIGNATURE_PATTERN,
    parameter int unsigned WATCHDOG_CONTROL_TICKS = params::WATCHDOG_CONTROL_TICKS
) (
    input  logic         reset,
    input  types::byte_t data_in,
    input  logic         enable,
    input  logic         clk,
    output logic         sys_reset,
    output logic         done
);
    import types::*;
    import params::*;

    // Wide enough to hold the reload value itself
    localparam int TICK_W = $clog2(WATCHDOG_CONTROL_TICKS + 1);
    localparam int SIG_W  = $clog2(WATCHDOG_SIGBYTES + 1);

    typedef logic [TICK_W-1:0] tick_t;
    typedef logic [SIG_W-1:0]  sig_cnt_t;

    typedef enum logic {
        S_SIG_CAPTURE,
        S_DONE
    } wd_state_t;

    wd_state_t         state;
    watchdog_pattern_t cache;
    watchdog_pattern_t cache_next;
    tick_t             tick_cnt;
    sig_cnt_t          sig_left;

    assign cache_next = (cache << 8) | watchdog_pattern_t'(data_in);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_SIG_CAPTURE;
            cache     <= '0;
            tick_cnt  <= tick_t'(WATCHDOG_CONTROL_TICKS);
            sig_left  <= sig_cnt_t'(WATCHDOG_SIGBYTES);
            done      <= 1'b0;
            sys_reset <= 1'b0;
        end else begin
            sys_reset <= (tick_cnt == '0);
            done      <= 1'b0;
            tick_cnt  <= tick_cnt - 1'b1;  // Free-running, wraps through zero
            case (state)
                S_SIG_CAPTURE: begin
                    if (enable) begin
                        cache <= cache_next;
                        if (cache_next == WATCHDOG_SIGNATURE_PATTERN) tick_cnt <= tick_t'(WATCHDOG_CONTROL_TICKS);
                        if (sig_left == sig_cnt_t'(1)) begin
                            state <= S_DONE;
                            done  <= 1'b1;
                        end else begin
                            sig_left <= sig_left - 1'b1;
                        end
                    end
                end
                S_DONE: begin
                    // Start the next kick from an empty capture
                    cache    <= '0;
                    sig_left <= sig_cnt_t'(WATCHDOG_SIGBYTES);
                    state    <= S_SIG_CAPTURE;
                end
                default: state <= S_SIG_CAPTURE;
            endcase
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (reset)
        done |=> !done);

    a_reset_single: assert property (@(posedge clk) disable iff (reset)
        sys_reset |=> !sys_reset);

endmodule

`default_nettype wire

// File: design/control_reg_write.sv
/* Register write handler, takes an address byte then a data byte */
`timescale 1ns/10ps
`default_nettype none

module control_reg_write #(
    parameter int NUM_CTRL_REGS = params::NUM_CTRL_REGS
) (
    input  logic                             clk,
    input  logic                             reset,
    input  types::byte_t                     data_in,
    input  logic                             enable,
    output types::byte_t [NUM_CTRL_REGS-1:0] ctrl_regs,
    output logic                             done
);
    import types::*;

    typedef enum logic {
        S_ADDR,
        S_DATA
    } wr_state_t;

    wr_state_t state;
    reg_addr_t addr;
    logic      addr_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_ADDR;
            addr      <= '0;
            addr_ok   <= 1'b0;
            done      <= 1'b0;
            ctrl_regs <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                S_ADDR: begin
                    if (enable) begin
                        addr    <= reg_addr_t'(data_in);
                        addr_ok <= (int'(data_in) < NUM_CTRL_REGS);
                        state   <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (enable) begin
                        // Bad address still consumes the data byte and completes
                        if (addr_ok) ctrl_regs[addr] <= data_in;
                        done  <= 1'b1;
                        state <= S_ADDR;
                    end
                end
                default: state <= S_ADDR;
            endcase
        end
    end

    a_done_after_byte: assert property (@(posedge clk) disable iff (reset)
        done |-> $past(enable));

endmodule

`default_nettype wire

// File: design/control_top.sv
/* Top level of the command front end: UART receiver, dispatcher and the
   watchdog and register write handlers */
`timescale 1ns/10ps
`default_nettype none

module control_top #(
    parameter int CLKS_PER_BIT = params::CLKS_PER_BIT,
    parameter types::watchdog_pattern_t WATCHDOG_SIGNATURE_PATTERN =
        params::WATCHDOG_SIGNATURE_PATTERN,
    parameter int unsigned WATCHDOG_CONTROL_TICKS = params::WATCHDOG_CONTROL_TICKS
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     rx,
    output logic                                     sys_reset,
    output types::byte_t [params::NUM_CTRL_REGS-1:0] ctrl_regs,
    output logic                                     cmd_error
);
    import types::*;
    import params::*;

    byte_t rx_data;
    logic  rx_valid;
    byte_t cmd_data;
    logic  wd_enable;
    logic  reg_enable;
    logic  wd_done;
    logic  reg_done;

    uart_byte_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_byte_rx (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    control_cmd_dispatch #(
        .OPCODE_WATCHDOG  (OPCODE_WATCHDOG),
        .OPCODE_REG_WRITE (OPCODE_REG_WRITE)
    ) u_control_cmd_dispatch (
        .clk        (clk),
        .reset      (reset),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .wd_done    (wd_done),
        .reg_done   (reg_done),
        .cmd_data   (cmd_data),
        .wd_enable  (wd_enable),
        .reg_enable (reg_enable),
        .cmd_error  (cmd_error)
    );

    control_cmd_watchdog #(
        .WATCHDOG_SIGNATURE_PATTERN (WATCHDOG_SIGNATURE_PATTERN),
        .WATCHDOG_CONTROL_TICKS     (WATCHDOG_CONTROL_TICKS)
    ) u_control_cmd_watchdog (
        .reset     (reset),
        .data_in   (cmd_data),
        .enable    (wd_enable),
        .clk       (clk),
        .sys_reset (sys_reset),
        .done      (wd_done)
    );

    control_reg_write #(
        .NUM_CTRL_REGS (NUM_CTRL_REGS)
    ) u_control_reg_write (
        .clk       (clk),
        .reset     (reset),
        .data_in   (cmd_data),
        .enable    (reg_enable),
        .ctrl_regs (ctrl_regs),
        .done      (reg_done)
    );

endmodule

`default_nettype wire

// File: testbench/control_checker.sv
/* Output monitor for the command front end that compares the register bank, error pulses
   and watchdog reset pulses with the expected values of each test */
`timescale 1ns/10ps
`default_nettype none

module control_checker #(
    parameter int NUM_REGS  = params::NUM_CTRL_REGS,
    parameter int TICKS     = params::WATCHDOG_CONTROL_TICKS,
    parameter int CMD_CLKS  = 200,
    parameter int BYTE_CLKS = 40
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        sys_reset,
    input  logic                        cmd_error,
    input  types::byte_t [NUM_REGS-1:0] ctrl_regs,
    input  logic                        kick,
    input  logic                        check,
    input  int                          test_idx,
    input  types::byte_t [NUM_REGS-1:0] exp_regs,
    input  int                          exp_errors,
    input  int                          exp_resets,
    output int                          tests_run,
    output int                          fail_count
);
    int   since_kick;   // Cycles since the last correct signature finished
    int   errors_seen;
    int   resets_seen;
    int   test_fails;
    logic reset_d;

    task automatic report_fail(input string msg);
        $display("[FAIL] %0d ns: %s", $time, msg);
        fail_count = fail_count + 1;
        test_fails = test_fails + 1;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            since_kick  = 0;
            errors_seen = 0;
            resets_seen = 0;
            test_fails  = 0;
            tests_run   = 0;
            fail_count  = 0;
        end else begin
            if (reset_d && ctrl_regs !== '0)
                report_fail($sformatf("ctrl_regs is %h right after reset", ctrl_regs));
            since_kick = kick ? 0 : since_kick + 1;
            if (cmd_error) errors_seen = errors_seen + 1;
            if (sys_reset) begin
                resets_seen = resets_seen + 1;
                // A starved counter must expire about TICKS cycles after the last kick
                if (since_kick < TICKS - CMD_CLKS || since_kick > TICKS + BYTE_CLKS)
                    report_fail($sformatf(
                        "sys_reset came %0d cycles after the last kick, window %0d to %0d",
                        since_kick, TICKS - CMD_CLKS, TICKS + BYTE_CLKS));
            end
            if (check) begin
                if (ctrl_regs !== exp_regs)
                    report_fail($sformatf("ctrl_regs is %h, expected %h", ctrl_regs, exp_regs));
                if (errors_seen != exp_errors)
                    report_fail($sformatf("%0d cmd_error pulses, expected %0d",
                        errors_seen, exp_errors));
                if (resets_seen != exp_resets)
                    report_fail($sformatf("%0d sys_reset pulses, expected %0d",
                        resets_seen, exp_resets));
                $display("Test %0d %s", test_idx, (test_fails == 0) ? "passed" : "failed");
                tests_run   = tests_run + 1;
                errors_seen = 0;
                resets_seen = 0;
                test_fails  = 0;
            end
        end
        reset_d = reset;
    end

endmodule

`default_nettype wire

// File: testbench/control_top_tb.sv
/* Testbench top: clock, reset, command table, serial line driver and cycle limit */
`timescale 1ns/10ps
`default_nettype none

module control_top_tb;
    import types::*;
    import params::*;

    localparam int    TB_CLKS_PER_BIT = 4;
    localparam int    TB_TICKS        = 600;
    localparam int    BYTE_CLKS       = 10 * TB_CLKS_PER_BIT;
    localparam int    CMD_CLKS        = 5 * BYTE_CLKS;  // Longest command, a watchdog kick
    localparam int    N_TESTS         = 15;
    localparam int    MAX_BYTES       = 5;
    localparam int    MARGIN          = 200;
    localparam byte_t OPCODE_UNKNOWN  = 8'h5A;

    logic clk = 1'b0;
    logic reset;
    logic rx;
    logic sys_reset;
    logic cmd_error;
    logic kick;
    logic check;
    int   test_idx;
    int   exp_errors;
    int   exp_resets;
    int   tests_run;
    int   fail_count;
    int   n_entries;
    int   cycle_count = 0;
    int   cycle_limit = 1000000;
    byte_t [NUM_CTRL_REGS-1:0] ctrl_regs;
    byte_t [NUM_CTRL_REGS-1:0] exp_regs;
    byte_t [NUM_CTRL_REGS-1:0] model_regs;

    // One row per test: serial bytes, idle gap, expected results
    byte_t                     tbl_bytes [N_TESTS][MAX_BYTES];
    int                        tbl_len   [N_TESTS];
    int                        tbl_gap   [N_TESTS];
    int                        tbl_err   [N_TESTS];
    int                        tbl_rst   [N_TESTS];
    logic                      tbl_kick  [N_TESTS];
    byte_t [NUM_CTRL_REGS-1:0] tbl_regs  [N_TESTS];

    control_top #(
        .CLKS_PER_BIT           (TB_CLKS_PER_BIT),
        .WATCHDOG_CONTROL_TICKS (TB_TICKS)
    ) u_control_top (
        .clk       (clk),
        .reset     (reset),
        .rx        (rx),
        .sys_reset (sys_reset),
        .ctrl_regs (ctrl_regs),
        .cmd_error (cmd_error)
    );

    control_checker #(
        .NUM_REGS  (NUM_CTRL_REGS),
        .TICKS     (TB_TICKS),
        .CMD_CLKS  (CMD_CLKS),
        .BYTE_CLKS (BYTE_CLKS)
    ) u_control_checker (
        .clk        (clk),
        .reset      (reset),
        .sys_reset  (sys_reset),
        .cmd_error  (cmd_error),
        .ctrl_regs  (ctrl_regs),
        .kick       (kick),
        .check      (check),
        .test_idx   (test_idx),
        .exp_regs   (exp_regs),
        .exp_errors (exp_errors),
        .exp_resets (exp_resets),
        .tests_run  (tests_run),
        .fail_count (fail_count)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run went past its limit of %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic push_entry(input int len, input byte_t b0, input byte_t b1, input byte_t b2,
                              input byte_t b3, input byte_t b4, input int gap, input int errs,
                              input int resets, input logic good_kick);
        tbl_len[n_entries]      = len;
        tbl_bytes[n_entries][0] = b0;
        tbl_bytes[n_entries][1] = b1;
        tbl_bytes[n_entries][2] = b2;
        tbl_bytes[n_entries][3] = b3;
        tbl_bytes[n_entries][4] = b4;
        tbl_gap[n_entries]      = gap;
        tbl_err[n_entries]      = errs;
        tbl_rst[n_entries]      = resets;
        tbl_kick[n_entries]     = good_kick;
        tbl_regs[n_entries]     = model_regs;
        n_entries = n_entries + 1;
    endtask

    task automatic add_kick(input logic good, input int gap, input int resets);
        watchdog_pattern_t sig;
        // A bad kick differs from the signature in its last byte only
        sig = good ? WATCHDOG_SIGNATURE_PATTERN : (WATCHDOG_SIGNATURE_PATTERN ^ 32'h0000_00FF);
        push_entry(5, OPCODE_WATCHDOG, sig[31:24], sig[23:16], sig[15:8], sig[7:0],
                   gap, 0, resets, good);
    endtask

    task automatic add_reg_write(input logic after_unknown, input byte_t addr, input int gap,
                                 input int resets);
        byte_t data;
        data = byte_t'($urandom);
        if (int'(addr) < NUM_CTRL_REGS) model_regs[addr[1:0]] = data;
        if (after_unknown)
            push_entry(4, OPCODE_UNKNOWN, OPCODE_REG_WRITE, addr, data, 8'h00, gap, 1, resets, 1'b0);
        else
            push_entry(3, OPCODE_REG_WRITE, addr, data, 8'h00, 8'h00, gap, 0, resets, 1'b0);
    endtask

    task automatic build_table();
        model_regs = '0;
        n_entries  = 0;
        add_kick(1'b1, 20, 0);               // First command straight out of reset
        add_reg_write(1'b0, 8'd0, 20, 0);
        add_reg_write(1'b0, 8'd3, 20, 0);
        add_kick(1'b1, 20, 0);
        add_reg_write(1'b0, 8'd1, 20, 0);
        add_reg_write(1'b0, 8'd7, 20, 0);    // Out of range, bank unchanged
        add_kick(1'b1, 20, 0);
        add_reg_write(1'b1, 8'd2, 20, 0);
        add_kick(1'b1, 20, 0);
        add_kick(1'b0, 600, 1);              // Wrong signature lets the counter run out
        add_kick(1'b1, 20, 0);
        add_reg_write(1'b0, 8'd2, 20, 0);
        add_kick(1'b1, 20, 0);
        add_reg_write(1'b0, 8'd0, 560, 1);   // Then silence until the reset pulse
        add_kick(1'b1, 20, 0);
    endtask

    // 8N1 frame, LSB first
    task automatic send_byte(input byte_t b);
        rx = 1'b0;
        repeat (TB_CLKS_PER_BIT) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rx = b[i];
            repeat (TB_CLKS_PER_BIT) @(negedge clk);
        end
        rx = 1'b1;
        repeat (TB_CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic apply_entry(input int idx);
        for (int j = 0; j < tbl_len[idx]; j++) send_byte(tbl_bytes[idx][j]);
        if (tbl_kick[idx]) begin
            kick = 1'b1;
            @(negedge clk);
            kick = 1'b0;
        end
        repeat (tbl_gap[idx]) @(negedge clk);
        test_idx   = idx;
        exp_regs   = tbl_regs[idx];
        exp_errors = tbl_err[idx];
        exp_resets = tbl_rst[idx];
        check      = 1'b1;
        @(negedge clk);
        check = 1'b0;
    endtask

    initial begin
        reset      = 1'b1;
        rx         = 1'b1;
        kick       = 1'b0;
        check      = 1'b0;
        test_idx   = 0;
        exp_regs   = '0;
        exp_errors = 0;
        exp_resets = 0;
        void'($urandom(50));
        build_table();
        cycle_limit = 5 + MARGIN;
        for (int i = 0; i < n_entries; i++)
            cycle_limit = cycle_limit + tbl_len[i] * BYTE_CLKS + tbl_gap[i] + 2;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < n_entries; i++) apply_entry(i);
        @(negedge clk);
        $display("Tests run: %0d of %0d, failed checks: %0d", tests_run, N_TESTS, fail_count);
        if (tests_run != N_TESTS) $display("Not every test reached its check");
        if (fail_count == 0 && tests_run == N_TESTS) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: control_top.f
design/types.sv
design/params.sv
design/uart_byte_rx.sv
design/control_cmd_dispatch.sv
design/control_cmd_watchdog.sv
design/control_reg_write.sv
design/control_top.sv
testbench/control_checker.sv
testbench/control_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench and RTL with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module control_top_tb \
    -f control_top.f -o control_top_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/control_top_sim > sim.log 2>&1
grep -q "All checks passed" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
